// File: rtl/fpga_core_params.svh
// Build-time sizing; FPGA_SEL_W must be wide enough to index FPGA_CH_CNT channels.
`ifndef FPGA_CORE_PARAMS_SVH
`define FPGA_CORE_PARAMS_SVH

// Number of Ethernet channels in the core.
`define FPGA_CH_CNT 4

// Width of the statistics channel select.
`define FPGA_SEL_W 2

`endif

// File: rtl/xgmii_pkg.sv
// Shared XGMII types and control codes; lane 0 is the low byte and the only lanes used are 0 to 7.
package xgmii_pkg;

    localparam int XGMII_LANES = 8; // Byte lanes per 64-bit word.

    // Control characters seen on lanes with rxc set.
    localparam logic [7:0] XGMII_START = 8'hFB; // Only valid in lane 0 or lane 4.
    localparam logic [7:0] XGMII_TERM  = 8'hFD;
    localparam logic [7:0] XGMII_ERROR = 8'hFE;
    localparam logic [7:0] XGMII_IDLE  = 8'h07;

    // One data word, read per lane or per 32-bit column group.
    typedef union packed {
        logic [XGMII_LANES-1:0][7:0] octet; // octet[0] is lane 0.
        logic [1:0][31:0]            half;  // half[0] holds lanes 0 to 3.
    } xgmii_word_u;

    // Statistics counter width. Counters wrap.
    typedef logic [31:0] stat_t;

    // Octets found in one word, 0 to 8.
    typedef logic [3:0] lane_cnt_t;

endpackage

// File: rtl/xgmii_rx_framer.sv
// Frame boundary tracking only; no CRC or preamble checks, and at most one frame end per word.
`timescale 1ns/100ps

module xgmii_rx_framer (
    input  logic                clk,
    input  logic                rst_n,
    input  xgmii_pkg::xgmii_word_u rxd,
    input  logic [7:0]          rxc,
    output logic                in_frame,       // Frame open after the last word.
    output logic                frame_open,     // A valid start was seen.
    output logic                frame_good_end, // Terminate with no error.
    output logic                frame_bad_end   // Error seen or cut off by a new start.
);
    import xgmii_pkg::*;

    logic       open_q;   // Frame currently open.
    logic       err_q;    // Error character seen in the open frame.
    logic       open_nxt;
    logic       err_nxt;
    logic       opened;
    logic       good_end;
    logic       bad_end;
    logic [7:0] start_ok; // Lanes where a start is legal and present.

    // Start is only legal at the head of a column group.
    assign start_ok = {3'b000, rxc[4] && (rxd.half[1][7:0] == XGMII_START),
                       3'b000, rxc[0] && (rxd.half[0][7:0] == XGMII_START)};

    // Walk the lanes in order and apply the framing rule.
    always_comb begin
        open_nxt = open_q;
        err_nxt  = err_q;
        opened   = 1'b0;
        good_end = 1'b0;
        bad_end  = 1'b0;
        for (int i = 0; i < XGMII_LANES; i++) begin
            if (rxc[i]) begin
                if (start_ok[i]) begin
                    if (open_nxt && !(good_end || bad_end)) begin
                        bad_end = 1'b1; // Old frame cut off.
                    end
                    open_nxt = 1'b1;
                    err_nxt  = 1'b0;    // Fresh frame.
                    opened   = 1'b1;
                end else if (rxd.octet[i] == XGMII_START) begin
                    if (open_nxt) begin
                        err_nxt = 1'b1; // Misplaced start inside a frame.
                    end
                end else if (rxd.octet[i] == XGMII_TERM && open_nxt) begin
                    if (!(good_end || bad_end)) begin
                        good_end = !err_nxt;
                        bad_end  = err_nxt;
                    end
                    open_nxt = 1'b0;    // Frame closed.
                end else if (rxd.octet[i] == XGMII_ERROR && open_nxt) begin
                    err_nxt = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            open_q         <= 1'b0;
            err_q          <= 1'b0;
            frame_open     <= 1'b0;
            frame_good_end <= 1'b0;
            frame_bad_end  <= 1'b0;
        end else begin
            open_q         <= open_nxt;
            err_q          <= err_nxt;
            frame_open     <= opened;   // Pulses are one cycle wide.
            frame_good_end <= good_end;
            frame_bad_end  <= bad_end;
        end
    end

    assign in_frame = open_q; // Registered state, aligned with the pulses.

endmodule

// File: rtl/xgmii_octet_counter.sv
// Per-word octet count; a word whose terminate comes before its start counts zero octets.
`timescale 1ns/100ps

module xgmii_octet_counter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  xgmii_pkg::xgmii_word_u rxd,
    input  logic [7:0]             rxc,
    output xgmii_pkg::lane_cnt_t   word_octets
);
    import xgmii_pkg::*;

    logic      has_start;
    logic      has_term;
    logic [2:0] start_pos; // First legal start lane.
    logic [2:0] term_pos;  // First terminate lane.
    lane_cnt_t cnt;

    // Find the first start and the first terminate in the word.
    always_comb begin
        has_start = 1'b0;
        has_term  = 1'b0;
        start_pos = 3'd0;
        term_pos  = 3'd0;
        for (int i = XGMII_LANES - 1; i >= 0; i--) begin // Lowest lane wins.
            if (rxc[i] && rxd.octet[i] == XGMII_START && (i % 4) == 0) begin
                has_start = 1'b1;
                start_pos = 3'(i);
            end
            if (rxc[i] && rxd.octet[i] == XGMII_TERM) begin
                has_term = 1'b1;
                term_pos = 3'(i);
            end
        end
    end

    // Count data lanes after the start and before the terminate.
    always_comb begin
        cnt = '0;
        for (int i = 0; i < XGMII_LANES; i++) begin
            if (!rxc[i] && (!has_start || i > start_pos) && (!has_term || i < term_pos)) begin
                cnt = cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_octets <= '0;
        end else begin
            word_octets <= cnt; // Aligned with the framer pulses.
        end
    end

endmodule

// File: rtl/xgmii_ch_stats.sv
// Receive counters for one channel; all counters wrap and bad frames add no octets.
`timescale 1ns/100ps

module xgmii_ch_stats (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_frame,
    input  logic                 frame_open,
    input  logic                 frame_good_end,
    input  logic                 frame_bad_end,
    input  xgmii_pkg::lane_cnt_t word_octets,
    output xgmii_pkg::stat_t     frames,
    output xgmii_pkg::stat_t     bad_frames,
    output xgmii_pkg::stat_t     octets
);
    import xgmii_pkg::*;

    stat_t total_q;   // Octets of the open frame so far.
    stat_t base;
    stat_t frame_sum; // Octets of the frame closing this cycle.
    stat_t word_ext;
    logic  one_word;  // Frame opened and closed in the same word.

    assign word_ext  = stat_t'(word_octets);
    assign one_word  = frame_open && !in_frame;
    assign base      = one_word ? '0 : total_q; // A one-word frame has no history.
    assign frame_sum = base + word_ext;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            total_q    <= '0;
            frames     <= '0;
            bad_frames <= '0;
            octets     <= '0;
        end else begin
            if (frame_open) begin
                total_q <= word_ext;           // Restart on a new frame.
            end else if (in_frame) begin
                total_q <= total_q + word_ext; // Middle of a frame.
            end
            if (frame_good_end) begin
                frames <= frames + 1'b1;
                octets <= octets + frame_sum;
            end
            if (frame_bad_end) begin
                bad_frames <= bad_frames + 1'b1; // Octets dropped.
            end
        end
    end

endmodule

// File: rtl/xgmii_channel.sv
// One loopback channel with receive statistics; no PHY clock domain, runs on the core clock.
`timescale 1ns/100ps

module xgmii_channel (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [63:0]      rxd,
    input  logic [7:0]       rxc,
    output logic [63:0]      txd,
    output logic [7:0]       txc,
    output xgmii_pkg::stat_t frames,
    output xgmii_pkg::stat_t bad_frames,
    output xgmii_pkg::stat_t octets
);
    import xgmii_pkg::*;

    xgmii_word_u rx_word;     // Received word, lane views.
    logic        in_frame;
    logic        frame_open;
    logic        frame_good_end;
    logic        frame_bad_end;
    lane_cnt_t   word_octets;

    assign rx_word = xgmii_word_u'(rxd);

    // Loopback register. Idles out of reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            txd <= {XGMII_LANES{XGMII_IDLE}};
            txc <= '1;
        end else begin
            txd <= rxd;
            txc <= rxc;
        end
    end

    xgmii_rx_framer framer0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .rxd            (rx_word),
        .rxc            (rxc),
        .in_frame       (in_frame),
        .frame_open     (frame_open),
        .frame_good_end (frame_good_end),
        .frame_bad_end  (frame_bad_end)
    );

    xgmii_octet_counter octets0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .rxd         (rx_word),
        .rxc         (rxc),
        .word_octets (word_octets)
    );

    xgmii_ch_stats stats0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_frame       (in_frame),
        .frame_open     (frame_open),
        .frame_good_end (frame_good_end),
        .frame_bad_end  (frame_bad_end),
        .word_octets    (word_octets),
        .frames         (frames),
        .bad_frames     (bad_frames),
        .octets         (octets)
    );

endmodule

// File: rtl/fpga_core.sv
// Multi-channel XGMII loopback core; single clock for all channels, stat outputs are combinational.
`timescale 1ns/100ps
`include "fpga_core_params.svh"

module fpga_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`FPGA_CH_CNT*64-1:0] eth_rxd,
    input  logic [`FPGA_CH_CNT*8-1:0]  eth_rxc,   // Set bit marks a control lane.
    output logic [`FPGA_CH_CNT*64-1:0] eth_txd,
    output logic [`FPGA_CH_CNT*8-1:0]  eth_txc,
    input  logic [`FPGA_SEL_W-1:0]     stat_sel,  // Channel whose counters are read.
    output xgmii_pkg::stat_t           stat_frames,
    output xgmii_pkg::stat_t           stat_bad,
    output xgmii_pkg::stat_t           stat_octets
);
    import xgmii_pkg::*;

    stat_t ch_frames [`FPGA_CH_CNT]; // Per-channel counters.
    stat_t ch_bad    [`FPGA_CH_CNT];
    stat_t ch_octets [`FPGA_CH_CNT];

    genvar n;

    generate
        for (n = 0; n < `FPGA_CH_CNT; n++) begin : ch
            xgmii_channel ch0 (
                .clk        (clk),
                .rst_n      (rst_n),
                .rxd        (eth_rxd[n*64 +: 64]),
                .rxc        (eth_rxc[n*8 +: 8]),
                .txd        (eth_txd[n*64 +: 64]),
                .txc        (eth_txc[n*8 +: 8]),
                .frames     (ch_frames[n]),
                .bad_frames (ch_bad[n]),
                .octets     (ch_octets[n])
            );
        end
    endgenerate

    // Read mux. A select past the last channel reads zero.
    always_comb begin
        stat_frames = '0;
        stat_bad    = '0;
        stat_octets = '0;
        if (int'(stat_sel) < `FPGA_CH_CNT) begin
            stat_frames = ch_frames[stat_sel];
            stat_bad    = ch_bad[stat_sel];
            stat_octets = ch_octets[stat_sel];
        end
    end

endmodule

// File: testbench/fpga_core_props.sv
// Framer pulse and loopback reset checks on every channel; assumes the synchronous active-low rst_n.
`timescale 1ns/100ps

module xgmii_channel_props (
    input logic       clk,
    input logic       rst_n,
    input logic       in_frame,
    input logic       frame_open,
    input logic       frame_good_end,
    input logic       frame_bad_end,
    input logic [7:0] txc
);

    // A frame ends either good or bad, never both.
    end_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(frame_good_end && frame_bad_end))
        else $error("framer raised good and bad end in the same cycle");

    // An opened frame stays open unless it closed in the same word.
    open_holds: assert property (@(posedge clk) disable iff (!rst_n)
        frame_open |-> in_frame || frame_good_end || frame_bad_end)
        else $error("frame_open without in_frame");

    // Loopback sends control lanes while held in reset.
    reset_idle: assert property (@(posedge clk)
        !rst_n |=> txc == 8'hFF)
        else $error("txc not all ones after reset");

endmodule

bind xgmii_channel xgmii_channel_props props0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_frame       (in_frame),
    .frame_open     (frame_open),
    .frame_good_end (frame_good_end),
    .frame_bad_end  (frame_bad_end),
    .txc            (txc)
);

// File: testbench/test_fpga_core.sv
// Prebuilt word streams for all channels; a frame never puts a terminate and a start in one word.
`timescale 1ns/100ps
`include "fpga_core_params.svh"

module test_fpga_core;
    import xgmii_pkg::*;

    localparam int          MAX_WORDS = 512;         // Stream depth per channel.
    localparam int          SEL_W     = `FPGA_SEL_W;
    localparam logic [63:0] IDLE_WORD = {8{XGMII_IDLE}};

    logic                       clk;
    logic                       rst_n;
    logic [`FPGA_CH_CNT*64-1:0] eth_rxd;
    logic [`FPGA_CH_CNT*8-1:0]  eth_rxc;
    logic [`FPGA_CH_CNT*64-1:0] eth_txd;
    logic [`FPGA_CH_CNT*8-1:0]  eth_txc;
    logic [SEL_W-1:0]           stat_sel;
    stat_t                      stat_frames;
    stat_t                      stat_bad;
    stat_t                      stat_octets;

    logic [63:0] rxd_mem [`FPGA_CH_CNT][MAX_WORDS]; // Received words per channel.
    logic [7:0]  rxc_mem [`FPGA_CH_CNT][MAX_WORDS];
    int          fill [`FPGA_CH_CNT];                // Lanes written so far.
    int          ckpt [8];                           // Word index of each stats read.
    int          n_ckpt;
    int          n_words;
    int          pos;
    int          cycles;
    int          limit = 1000000;                    // Replaced once streams are built.
    logic [`FPGA_CH_CNT*64-1:0] rxd_d;               // Input seen one cycle back.
    logic [`FPGA_CH_CNT*8-1:0]  rxc_d;
    logic                       rst_low_d = 1'b1;

    fpga_core dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .eth_rxd     (eth_rxd),
        .eth_rxc     (eth_rxc),
        .eth_txd     (eth_txd),
        .eth_txc     (eth_txc),
        .stat_sel    (stat_sel),
        .stat_frames (stat_frames),
        .stat_bad    (stat_bad),
        .stat_octets (stat_octets)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 100 MHz.
    end

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    function automatic void put_lane(input int ch, input logic [7:0] b, input logic c);
        rxd_mem[ch][fill[ch] / 8][(fill[ch] % 8) * 8 +: 8] = b;
        rxc_mem[ch][fill[ch] / 8][fill[ch] % 8] = c;
        fill[ch]++;
    endfunction

    // Start, len octets and an optional terminate.
    // The start and end words are filled out with data lanes that lie outside the frame.
    function automatic void frame_words(input int ch, input int len, input int start_lane,
                                        input bit inject_err, input bit close);
        int err_at;
        err_at = inject_err ? len / 2 : -1;
        while (fill[ch] % 8 != start_lane) put_lane(ch, 8'($urandom), 1'b0);
        put_lane(ch, XGMII_START, 1'b1);
        for (int i = 0; i < len; i++) begin
            if (i == err_at) put_lane(ch, XGMII_ERROR, 1'b1); // Error replaces a data octet.
            else put_lane(ch, 8'($urandom), 1'b0);
        end
        if (close) put_lane(ch, XGMII_TERM, 1'b1);
        while (fill[ch] % 8 != 0) put_lane(ch, 8'($urandom), 1'b0);
    endfunction

    function automatic void idle_words(input int ch, input int n);
        repeat (n * 8) put_lane(ch, XGMII_IDLE, 1'b1);
    endfunction

    // Random lanes; control lanes stay below 0x80 so no start, terminate or error.
    function automatic void random_words(input int ch, input int n);
        logic c;
        repeat (n * 8) begin
            c = 1'($urandom);
            put_lane(ch, c ? 8'($urandom & 32'h7F) : 8'($urandom), c);
        end
    endfunction

    // Pad all channels to one length, add a drain of idles and mark a stats read.
    function automatic void end_segment();
        int top;
        top = 0;
        for (int ch = 0; ch < `FPGA_CH_CNT; ch++) if (fill[ch] > top) top = fill[ch];
        top = top + 3 * 8; // Counters settle two cycles after the last word.
        for (int ch = 0; ch < `FPGA_CH_CNT; ch++) begin
            while (fill[ch] < top) put_lane(ch, XGMII_IDLE, 1'b1);
        end
        n_words = top / 8;
        ckpt[n_ckpt] = n_words;
        n_ckpt++;
    endfunction

    function automatic void build_tests();
        end_segment();                                   // Counters straight after reset.
        for (int ch = 0; ch < `FPGA_CH_CNT; ch++) random_words(ch, 20);
        end_segment();
        for (int ch = 0; ch < `FPGA_CH_CNT; ch++) begin  // Good frames, both start lanes.
            for (int f = 0; f < 4; f++) begin
                frame_words(ch, 8 + int'($urandom % 56), (f % 2) * 4, 1'b0, 1'b1);
                idle_words(ch, 1);
            end
        end
        end_segment();
        for (int ch = 0; ch < `FPGA_CH_CNT; ch++) begin  // Error frame, then a cut-off frame.
            frame_words(ch, 20 + ch, 0, 1'b1, 1'b1);
            idle_words(ch, 1);
            frame_words(ch, 30, 4, 1'b0, 1'b0);
            frame_words(ch, 12 + ch, 0, 1'b0, 1'b1);
            idle_words(ch, 1);
        end
        end_segment();
        for (int ch = 0; ch < `FPGA_CH_CNT; ch++) begin  // Different mix on each channel.
            for (int f = 0; f < ch + 2; f++) begin
                frame_words(ch, 8 + int'($urandom % 40), int'($urandom % 2) * 4,
                            ($urandom % 3) == 0, 1'b1);
                idle_words(ch, ch % 2 + 1);
            end
        end
        end_segment();
    endfunction

    // Framing and octet rules applied lane by lane to the first upto words.
    function automatic void ref_stats(input int ch, input int upto, output logic [31:0] frames,
                                      output logic [31:0] bad, output logic [31:0] octets);
        logic       is_open;
        logic       err;
        int         run;
        logic [7:0] b;
        frames  = '0;
        bad     = '0;
        octets  = '0;
        is_open = 1'b0;
        err     = 1'b0;
        run     = 0;
        for (int w = 0; w < upto; w++) begin
            for (int i = 0; i < 8; i++) begin
                b = rxd_mem[ch][w][i * 8 +: 8];
                if (!rxc_mem[ch][w][i]) begin
                    if (is_open) run++;              // Data lane inside a frame.
                end else if (b == XGMII_START && i % 4 == 0) begin
                    if (is_open) bad++;              // Cut off by a new start.
                    is_open = 1'b1;
                    err     = 1'b0;
                    run     = 0;
                end else if (b == XGMII_START || b == XGMII_ERROR) begin
                    if (is_open) err = 1'b1;
                end else if (b == XGMII_TERM && is_open) begin
                    if (err) begin
                        bad++;
                    end else begin
                        frames++;
                        octets += run;
                    end
                    is_open = 1'b0;
                end
            end
        end
    endfunction

    task automatic drive_word(input int w);
        for (int ch = 0; ch < `FPGA_CH_CNT; ch++) begin
            eth_rxd[ch * 64 +: 64] = rxd_mem[ch][w];
            eth_rxc[ch * 8 +: 8]   = rxc_mem[ch][w];
        end
        @(posedge clk);
        #1;
    endtask

    task automatic read_stats(input int upto);
        logic [31:0] e_frames;
        logic [31:0] e_bad;
        logic [31:0] e_octets;
        eth_rxd = {`FPGA_CH_CNT{IDLE_WORD}}; // Idles while reading.
        eth_rxc = '1;
        for (int ch = 0; ch < `FPGA_CH_CNT; ch++) begin
            stat_sel = SEL_W'(ch);
            ref_stats(ch, upto, e_frames, e_bad, e_octets);
            @(negedge clk);
            check_equal($sformatf("stat_frames[%0d]", ch), stat_frames, e_frames);
            check_equal($sformatf("stat_bad[%0d]", ch), stat_bad, e_bad);
            check_equal($sformatf("stat_octets[%0d]", ch), stat_octets, e_octets);
            @(posedge clk);
            #1;
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("Test failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // Loopback compare at mid-cycle, against the input of the previous cycle.
    always @(negedge clk) begin
        if (cycles > 0) begin
            for (int ch = 0; ch < `FPGA_CH_CNT; ch++) begin
                check_equal($sformatf("eth_txd[%0d]", ch), eth_txd[ch * 64 +: 64],
                            rst_low_d ? IDLE_WORD : rxd_d[ch * 64 +: 64]);
                check_equal($sformatf("eth_txc[%0d]", ch), eth_txc[ch * 8 +: 8],
                            rst_low_d ? 8'hFF : rxc_d[ch * 8 +: 8]);
            end
            rxd_d     = eth_rxd;
            rxc_d     = eth_rxc;
            rst_low_d = !rst_n; // Value the next edge samples.
        end
    end

    initial begin
        void'($urandom(49417));                      // One seed for the run.
        rst_n    = 1'b0;
        stat_sel = '0;
        eth_rxd  = {`FPGA_CH_CNT * 2{32'h5AA5_C33C}}; // Data lanes held during reset.
        eth_rxc  = '0;
        build_tests();
        limit = n_words + 100;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int k = 0; k < n_ckpt; k++) begin
            while (pos < ckpt[k]) begin
                drive_word(pos);
                pos++;
            end
            read_stats(ckpt[k]);
        end
        $display("Test passed");
        $finish;
    end

endmodule

// File: fpga_core.f
+incdir+rtl
rtl/xgmii_pkg.sv
rtl/xgmii_rx_framer.sv
rtl/xgmii_octet_counter.sv
rtl/xgmii_ch_stats.sv
rtl/xgmii_channel.sv
rtl/fpga_core.sv
testbench/fpga_core_props.sv
testbench/test_fpga_core.sv
